/* Makefile */
# Verilator build and run for the fcore control issue front end

TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = fcore_control_tb
FLIST = flist.f
BUILD = obj_dir
PASS  = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)

run: build
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

lint:
	$(TOOL) --lint-only --timing -Wall --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

/* bench/fcore_control_chk.sv */
// Issue sequencer checks
// Strobe widths, sticky fault and no beats once a fault is up

`timescale 1ns/100ps

module fcore_control_chk (
    input logic clock,
    input logic reset,
    input logic efi_start,
    input logic done,
    input logic fault,
    input logic issue
);

    int unsigned failures = 0;

    efi_start_pulse: assert property (@(posedge clock) disable iff (reset)
        efi_start |=> !efi_start)
        else begin
            failures = failures + 1;
            $error("efi_start held high for more than one cycle");
        end

    done_pulse: assert property (@(posedge clock) disable iff (reset) done |=> !done)
        else begin
            failures = failures + 1;
            $error("done held high for more than one cycle");
        end

    // Only reset clears an overrun
    fault_sticky: assert property (@(posedge clock) disable iff (reset) fault |=> fault)
        else begin
            failures = failures + 1;
            $error("fault fell without reset");
        end

    // A faulted sequencer issues nothing more
    no_issue_after_fault: assert property (@(posedge clock) disable iff (reset)
        fault |-> !issue)
        else begin
            failures = failures + 1;
            $error("beat issued after fault");
        end

endmodule

bind issue_sequencer fcore_control_chk u_chk (
    .clock     (clock),
    .reset     (reset),
    .efi_start (efi_start),
    .done      (done),
    .fault     (fault),
    .issue     (ctrl.issue)
);

/* bench/fcore_control_tb.sv */
// fcore control testbench
// Runs the golden programs, models the external function unit and checks every issued beat

`timescale 1ns/100ps

module fcore_control_tb;

    import fcore_pkg::*;

    localparam int beat_latency  = 3;
    localparam int max_wait      = 400;
    localparam int settle_cycles = 12;

    logic                   clock = 1'b0;
    logic                   reset;
    prog_write_t            prog_write;
    logic [pc_width:0]      program_size;
    logic [chan_width-1:0]  n_channels;
    logic                   run;
    logic                   efi_done = 1'b0;
    issue_beat_t            beat;
    logic [instr_width-1:0] load_data;
    logic                   efi_start;
    logic                   dma_enable;
    logic                   done;
    logic                   fault;

    logic [31:0]            gold [0:255];
    int                     gp;
    issue_beat_t            beats [$];
    logic [instr_width-1:0] loads [$];
    int                     efi_count = 0;
    int                     done_count = 0;
    int                     efi_wait = 0;
    int                     errors = 0;
    int                     failed_tests = 0;

    always #5 clock = ~clock;

    fcore_control u_fcore_control (
        .clock        (clock),
        .reset        (reset),
        .prog_write   (prog_write),
        .program_size (program_size),
        .n_channels   (n_channels),
        .run          (run),
        .efi_done     (efi_done),
        .beat         (beat),
        .load_data    (load_data),
        .efi_start    (efi_start),
        .dma_enable   (dma_enable),
        .done         (done),
        .fault        (fault)
    );

    // Outputs settle after the rising edge, so they are collected on the falling one
    always @(negedge clock) begin
        if (beat.valid) begin
            beats.push_back(beat);
            loads.push_back(load_data);
        end
        if (efi_start) begin
            efi_count++;
        end
        if (done) begin
            done_count++;
        end
    end

    // External function unit, answers each start after 1 to 8 cycles
    always @(negedge clock) begin
        // Issue stays quiet from the start strobe until efi_done has been driven
        if (beat.valid && (efi_start || efi_wait > 0)) begin
            $display("[FAIL] %0t: beat issued while the external function was busy", $time);
            errors++;
        end
        efi_done = 1'b0;
        if (efi_wait > 0) begin
            efi_wait--;
            efi_done = (efi_wait == 0);
        end
        if (efi_start) begin
            efi_wait = 1 + int'($urandom % 8);
        end
    end

    task automatic check_beat(input issue_beat_t got, input issue_beat_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: beat %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_load(input logic [instr_width-1:0] got,
                              input logic [instr_width-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: load_data %h, expected %h", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_outcome(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t: outcome fault,done = %b, expected %b", $time, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (8) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic write_word(input int addr, input logic [instr_width-1:0] data);
        prog_write = '{write: 1'b1, addr: pc_width'(addr), data: data};
        @(negedge clock);
    endtask

    task automatic run_once(input int group_base, input int n_groups, input logic [1:0] outcome,
                            input int efi_expected, input logic [instr_width-1:0] load_expected);
        int          cycles;
        int          idx;
        int          g;
        int          c;
        issue_beat_t expected;
        beats.delete();
        loads.delete();
        efi_count  = 0;
        done_count = 0;
        run = 1'b1;
        @(negedge clock);
        run = 1'b0;
        cycles = 1;
        while (!beat.valid && cycles < max_wait) begin
            @(negedge clock);
            cycles++;
        end
        if (beat.valid) begin
            check_count(cycles, beat_latency, "cycles from run to first beat");
            check_count(int'(dma_enable), 0, "dma_enable while running");
        end else begin
            $display("timeout: no beat came after run");
            errors++;
        end
        cycles = 0;
        while (!done && !fault && cycles < max_wait) begin
            @(negedge clock);
            cycles++;
        end
        if (done || fault) begin
            check_outcome({fault, done}, outcome);
            if (done) begin
                check_count(int'(dma_enable), 1, "dma_enable after done");
            end
        end else begin
            $display("timeout: neither done nor fault came");
            errors++;
        end
        // Window in which no further beat may appear
        repeat (settle_cycles) @(negedge clock);
        if (outcome[1]) begin
            check_outcome({fault, done}, outcome);
        end
        check_count(beats.size(), n_groups * int'(n_channels), "beat count");
        check_count(efi_count, efi_expected, "efi_start pulses");
        check_count(done_count, int'(outcome[0]), "done pulses");
        for (g = 0; g < n_groups; g++) begin
            for (c = 0; c < int'(n_channels); c++) begin
                idx = g * int'(n_channels) + c;
                expected = '{valid: 1'b1, data: gold[group_base + 2 * g + 1],
                             dest: chan_width'(c), user: gold[group_base + 2 * g][pc_width-1:0]};
                if (idx < beats.size()) begin
                    check_beat(beats[idx], expected);
                    if (expected.data[opcode_width-1:0] == op_ldc) begin
                        check_load(loads[idx], load_expected);
                    end
                end
            end
        end
    endtask

    task automatic run_test(input int index);
        int                     runs;
        int                     n_groups;
        int                     efi_expected;
        int                     group_base;
        int                     errors_before;
        int                     i;
        logic [1:0]             outcome;
        logic [instr_width-1:0] load_expected;
        errors_before = errors;
        n_channels    = gold[gp][chan_width-1:0];
        program_size  = gold[gp + 1][pc_width:0];
        outcome       = gold[gp + 2][1:0];
        runs          = int'(gold[gp + 3]);
        efi_expected  = int'(gold[gp + 4]);
        n_groups      = int'(gold[gp + 5]);
        load_expected = gold[gp + 6];
        gp = gp + 7;
        apply_reset();
        for (i = 0; i < int'(program_size); i++) begin
            write_word(i, gold[gp + i]);
        end
        prog_write.write = 1'b0;
        gp = gp + int'(program_size);
        group_base = gp;
        gp = gp + 2 * n_groups;
        for (i = 0; i < runs; i++) begin
            run_once(group_base, n_groups, outcome, efi_expected, load_expected);
        end
        if (errors == errors_before) begin
            $display("test %0d: %0d channels, %0d run(s), ok", index, n_channels, runs);
        end else begin
            $display("test %0d: %0d channels, %0d errors", index, n_channels,
                     errors - errors_before);
            failed_tests++;
        end
    endtask

    initial begin
        int n_tests;
        int t;
        void'($urandom(32'he1b38c5c));
        reset        = 1'b1;
        run          = 1'b0;
        prog_write   = '0;
        program_size = '0;
        n_channels   = 8'd1;
        $readmemh("bench/program_golden.txt", gold);
        n_tests = int'(gold[0]);
        gp = 1;
        @(negedge clock);
        for (t = 1; t <= n_tests; t++) begin
            run_test(t);
        end
        errors = errors + int'(u_fcore_control.u_issue_sequencer.u_chk.failures);
        $display("%0d tests, %0d failed, %0d errors", n_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* bench/program_golden.txt */
// Hex words read in order. First word is the number of tests, then per test a header line
// n_channels program_size outcome(1 done, 2 fault) runs efi_pulses n_groups load_data,
// the program words, and one pair per expected group: pc tag, issued word
6
// Plain sweep over three channels
3 4 1 1 0 4 0
A0000001 B0000042 C0000063 FF00000C
0 A0000001  1 B0000042  2 C0000063  3 FF00000C
// LDC with its operand in the following word
3 5 1 1 0 4 CAFEF00D
A0000001 12340006 CAFEF00D B0000042 FF00000C
0 A0000001  1 12340006  3 B0000042  4 FF00000C
// Two EFI calls over two channels
2 5 1 1 2 5 0
A0000001 55000015 C0000063 55000015 FF00000C
0 A0000001  1 55000015  2 C0000063  3 55000015  4 FF00000C
// STOP over four channels, run twice
4 3 1 2 0 3 0
D0000000 E0000027 FF00000C
0 D0000000  1 E0000027  2 FF00000C
// Overrun with no STOP
2 4 2 1 0 3 5EED1234
A0000001 12340006 5EED1234 B0000042
0 A0000001  1 12340006  3 B0000042
// Single channel with LDC and EFI
1 5 1 1 1 4 0BADCAFE
A0000001 12340006 0BADCAFE 55000015 FF00000C
0 A0000001  1 12340006  3 55000015  4 FF00000C

/* flist.f */
verilog/fcore_pkg.sv
verilog/program_store.sv
verilog/channel_sweep.sv
verilog/issue_stage.sv
verilog/issue_sequencer.sv
verilog/fcore_control.sv
bench/fcore_control_chk.sv
bench/fcore_control_tb.sv

/* verilog/channel_sweep.sv */
// Channel sweep
// Counts the destination channel of each beat and flags the end of a word's group

`timescale 1ns/100ps

module channel_sweep (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [fcore_pkg::chan_width-1:0]  n_channels,
    input  logic                              advance,
    input  logic                              restart,
    output logic                              group_end,
    output logic [fcore_pkg::chan_width-1:0]  chan_addr
);

    import fcore_pkg::*;

    logic [chan_width-1:0] count;

    // High while the beat for the last active channel is being issued
    assign group_end = (count == n_channels - 1'b1);

    always_ff @(posedge clock) begin
        if (reset || restart) begin
            count <= '0;
        end else if (advance) begin
            if (group_end) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // One cycle of lag puts the address next to the registered beat
    always_ff @(posedge clock) begin
        if (reset) begin
            chan_addr <= '0;
        end else begin
            chan_addr <= count;
        end
    end

endmodule

/* verilog/fcore_control.sv */
// fcore control top level
// Program store, issue sequencer, channel sweep and issue stage of the issue front end

`timescale 1ns/100ps

module fcore_control (
    input  logic                               clock,
    input  logic                               reset,
    input  fcore_pkg::prog_write_t             prog_write,
    input  logic [fcore_pkg::pc_width:0]       program_size,
    input  logic [fcore_pkg::chan_width-1:0]   n_channels,
    input  logic                               run,
    input  logic                               efi_done,
    output fcore_pkg::issue_beat_t             beat,
    output logic [fcore_pkg::instr_width-1:0]  load_data,
    output logic                               efi_start,
    output logic                               dma_enable,
    output logic                               done,
    output logic                               fault
);

    import fcore_pkg::*;

    wide_word_t            words;
    logic [pc_width-1:0]   pc;
    logic                  advance;
    logic                  restart;
    logic                  group_end;
    logic [chan_width-1:0] chan_addr;
    issue_ctrl_t           ctrl;

    program_store u_program_store (
        .clock      (clock),
        .reset      (reset),
        .prog_write (prog_write),
        .pc         (pc),
        .words      (words)
    );

    issue_sequencer u_issue_sequencer (
        .clock        (clock),
        .reset        (reset),
        .run          (run),
        .efi_done     (efi_done),
        .program_size (program_size),
        .words        (words),
        .group_end    (group_end),
        .pc           (pc),
        .advance      (advance),
        .restart      (restart),
        .ctrl         (ctrl),
        .efi_start    (efi_start),
        .dma_enable   (dma_enable),
        .done         (done),
        .fault        (fault)
    );

    channel_sweep u_channel_sweep (
        .clock      (clock),
        .reset      (reset),
        .n_channels (n_channels),
        .advance    (advance),
        .restart    (restart),
        .group_end  (group_end),
        .chan_addr  (chan_addr)
    );

    issue_stage u_issue_stage (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .words     (words),
        .chan_addr (chan_addr),
        .pc        (pc),
        .beat      (beat),
        .load_data (load_data)
    );

endmodule

/* verilog/fcore_pkg.sv */
// fcore control package
// Opcode set, widths and the packed structs shared by the issue front end

package fcore_pkg;

    localparam int instr_width  = 32;
    localparam int opcode_width = 5;
    localparam int pc_width     = 10;
    localparam int chan_width   = 8;

    // Only LDC, EFI and STOP change the sweep, the rest are passed through as issued
    typedef enum logic [opcode_width-1:0] {
        op_nop  = 5'd0,
        op_add  = 5'd1,
        op_sub  = 5'd2,
        op_mul  = 5'd3,
        op_itf  = 5'd4,
        op_fti  = 5'd5,
        op_ldc  = 5'd6,
        op_ldr  = 5'd7,
        op_stop = 5'd12,
        op_efi  = 5'd21
    } opcode_t;

    typedef struct packed {
        logic                   write;
        logic [pc_width-1:0]    addr;
        logic [instr_width-1:0] data;
    } prog_write_t;

    // The word at pc sits in the low half, its successor above it
    typedef struct packed {
        logic [instr_width-1:0] second;
        logic [instr_width-1:0] first;
    } wide_word_t;

    typedef struct packed {
        logic                   valid;
        logic [instr_width-1:0] data;
        logic [chan_width-1:0]  dest;
        logic [pc_width-1:0]    user;
    } issue_beat_t;

    typedef struct packed {
        logic issue;
        logic capture_ldc;
        logic clear;
    } issue_ctrl_t;

endpackage

/* verilog/issue_sequencer.sv */
// Issue sequencer
// FSM that walks the program, runs the LDC, EFI and STOP sequences and raises overrun faults

`timescale 1ns/100ps

module issue_sequencer (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             run,
    input  logic                             efi_done,
    input  logic [fcore_pkg::pc_width:0]     program_size,
    input  fcore_pkg::wide_word_t            words,
    input  logic                             group_end,
    output logic [fcore_pkg::pc_width-1:0]   pc,
    output logic                             advance,
    output logic                             restart,
    output fcore_pkg::issue_ctrl_t           ctrl,
    output logic                             efi_start,
    output logic                             dma_enable,
    output logic                             done,
    output logic                             fault
);

    import fcore_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_wait_load,
        st_run,
        st_efi_call,
        st_stop_drain,
        st_fault
    } state_t;

    state_t              state;
    logic [pc_width-1:0] pc_q;
    logic                mid_group;
    logic                efi_sent;
    opcode_t             opcode;
    logic                overrun;
    logic                issue;

    assign opcode  = opcode_t'(words.first[opcode_width-1:0]);
    assign overrun = {1'b0, pc_q} >= program_size;
    assign issue   = (state == st_run) && !overrun;
    assign advance = issue;
    assign restart = (state == st_idle);

    assign ctrl.issue       = issue;
    assign ctrl.capture_ldc = issue && !mid_group && (opcode == op_ldc);
    assign ctrl.clear       = (state == st_idle);

    // pc leaves this block one step ahead so that the store output holds the word at pc_q
    always_comb begin
        pc = pc_q;
        if (state == st_idle) begin
            pc = '0;
        end else if (issue && group_end) begin
            if (opcode == op_ldc) begin
                pc = pc_q + pc_width'(2);
            end else begin
                pc = pc_q + pc_width'(1);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_q <= '0;
        end else begin
            pc_q <= pc;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= st_idle;
            mid_group  <= 1'b0;
            efi_sent   <= 1'b0;
            efi_start  <= 1'b0;
            done       <= 1'b0;
            fault      <= 1'b0;
            dma_enable <= 1'b1;
        end else begin
            efi_start <= 1'b0;
            done      <= 1'b0;
            if (issue) begin
                mid_group <= !group_end;
            end
            case (state)
                st_idle: begin
                    mid_group <= 1'b0;
                    if (run) begin
                        dma_enable <= 1'b0;
                        state      <= st_wait_load;
                    end
                end
                // Gives the store one cycle to present the first word
                st_wait_load: begin
                    state <= st_run;
                end
                st_run: begin
                    if (overrun) begin
                        fault <= 1'b1;
                        state <= st_fault;
                    end else if (group_end) begin
                        if (opcode == op_efi) begin
                            state <= st_efi_call;
                        end else if (opcode == op_stop) begin
                            state <= st_stop_drain;
                        end
                    end
                end
                // Start strobe goes out once the last EFI beat is on the output
                st_efi_call: begin
                    efi_start <= !efi_sent;
                    efi_sent  <= 1'b1;
                    if (efi_done && efi_sent) begin
                        efi_sent <= 1'b0;
                        state    <= st_run;
                    end
                end
                st_stop_drain: begin
                    done       <= 1'b1;
                    dma_enable <= 1'b1;
                    state      <= st_idle;
                end
                // Only reset leaves here
                st_fault: begin
                    fault <= 1'b1;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

/* verilog/issue_stage.sv */
// Issue stage
// Registers each issued beat, repeats a held LDC word over its group and keeps the operand

`timescale 1ns/100ps

module issue_stage (
    input  logic                               clock,
    input  logic                               reset,
    input  fcore_pkg::issue_ctrl_t             ctrl,
    input  fcore_pkg::wide_word_t              words,
    input  logic [fcore_pkg::chan_width-1:0]   chan_addr,
    input  logic [fcore_pkg::pc_width-1:0]     pc,
    output fcore_pkg::issue_beat_t             beat,
    output logic [fcore_pkg::instr_width-1:0]  load_data
);

    import fcore_pkg::*;

    logic                   valid_q;
    logic [instr_width-1:0] data_q;
    logic [pc_width-1:0]    user_q;
    logic [pc_width-1:0]    pc_dly;
    logic [instr_width-1:0] ldc_word;
    logic                   blank;

    // The channel address already lags by one cycle, so it joins the beat directly
    assign beat = '{valid: valid_q, data: data_q, dest: chan_addr, user: user_q};

    // pc is the fetch address, so its delayed copy tags the words now at the store output
    always_ff @(posedge clock) begin
        pc_dly <= pc;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= 1'b0;
            blank   <= 1'b0;
        end else begin
            valid_q <= ctrl.issue;
            if (ctrl.clear) begin
                data_q    <= '0;
                user_q    <= '0;
                load_data <= '0;
                blank     <= 1'b0;
            end else if (ctrl.issue) begin
                if (blank) begin
                    data_q <= ldc_word;
                end else begin
                    data_q <= words.first;
                end
                user_q <= pc_dly;
                if (ctrl.capture_ldc) begin
                    ldc_word  <= words.first;
                    load_data <= words.second;
                    blank     <= 1'b1;
                end
            end
            // The fetch address moves on the last beat of a group, which ends blanking
            if (pc != pc_dly) begin
                blank <= 1'b0;
            end
        end
    end

endmodule

/* verilog/program_store.sv */
// Program store
// Single-port write, registered double-word read of the words at pc and pc+1

`timescale 1ns/100ps

module program_store (
    input  logic                             clock,
    input  logic                             reset,
    input  fcore_pkg::prog_write_t           prog_write,
    input  logic [fcore_pkg::pc_width-1:0]   pc,
    output fcore_pkg::wide_word_t            words
);

    import fcore_pkg::*;

    localparam int depth = 2 ** pc_width;

    logic [instr_width-1:0] mem [0:depth-1];
    logic [pc_width-1:0]    pc_next;

    // The operand of an LDC is read alongside it, wrapping at the top of the store
    assign pc_next = pc + 1'b1;

    always_ff @(posedge clock) begin
        if (prog_write.write) begin
            mem[prog_write.addr] <= prog_write.data;
        end
    end

    // Read port register, a write to the same address shows up one cycle later
    always_ff @(posedge clock) begin
        if (reset) begin
            words <= '0;
        end else begin
            words.first  <= mem[pc];
            words.second <= mem[pc_next];
        end
    end

endmodule
